/* Bender.yml */
package:
  name: cache_top

sources:
  - cache_pkg.sv
  - cache_fill_ctrl.sv
  - cache_tag_array.sv
  - cache_data_array.sv
  - cache_top.sv
  - target: test
    files:
      - tb_cache_top.sv

/* cache_data_array.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_data_array (
  input  logic                 clk,         // System clock.
  input  logic                 data_write,  // Write one fill word.
  input  logic                 fill_way,    // Way being refilled.
  input  logic                 hit_way,     // Way that matched the lookup.
  input  cache_pkg::word_sel_t fill_word,   // Word slot of the fill write.
  input  cache_pkg::word_t     fill_data,   // Word from memory.
  input  cache_pkg::addr_t     lookup_addr, // Address held in the lookup stage.
  output cache_pkg::word_t     rd_data      // Word returned to the processor.
);

  // Sets by ways by words in the line.
  cache_pkg::word_t line_mem [cache_pkg::NUM_SETS][2][cache_pkg::WORDS_PER_LINE];

  cache_pkg::index_t    set_idx;  // Set selected by the lookup address.
  cache_pkg::word_sel_t rd_word;  // Word selected by the lookup address.

  assign set_idx = lookup_addr[9:4]; // Same set serves both reads and fills.
  assign rd_word = lookup_addr[3:1]; // Word offset inside the line.

  ////////////////////////////////////////
  // Fill write port                    //
  ////////////////////////////////////////
  // The lookup address stays put for the whole fill.
  // So the fill write can share its set index with the read side.
  always_ff @(posedge clk) begin
    if (data_write) begin
      line_mem[set_idx][fill_way][fill_word] <= fill_data; // Store the word.
    end
  end

  ////////////////////////////////////////
  // Lookup read port                   //
  ////////////////////////////////////////
  assign rd_data = line_mem[set_idx][hit_way][rd_word]; // Combinational read.

endmodule

`default_nettype wire

/* cache_fill_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_fill_ctrl (
  input  logic                  clk,            // System clock.
  input  logic                  rst_n,          // Asynchronous reset, active low.
  input  logic                  lookup_valid,   // Lookup stage holds a real request.
  input  logic                  lookup_miss,    // Neither way matches the lookup address.
  input  logic                  hit_way,        // Way that matched, 1 means way 1.
  input  logic                  victim_is_way0, // LRU bit of the lookup set.
  input  logic                  mem_grant,      // Memory grant level.
  input  logic                  mem_data_valid, // Memory word strobe.
  input  cache_pkg::addr_t      lookup_addr,    // Address held in the lookup stage.
  input  cache_pkg::word_t      mem_data,       // Word returned by memory.
  output logic                  stall,          // Holds the processor and lookup stage.
  output logic                  mem_req,        // Memory request level.
  output logic                  tag_write,      // Writes tag, valid and LRU.
  output logic                  data_write,     // Writes one word into the data array.
  output logic                  fill_way,       // Way being refilled.
  output logic                  lru_set_first,  // New LRU bit for the lookup set.
  output cache_pkg::addr_t      mem_addr,       // Address of the word expected next.
  output cache_pkg::word_sel_t  fill_word,      // Word slot being written.
  output cache_pkg::word_t      fill_data       // Word being written.
);

  cache_pkg::fill_state_t state;         // Current fill state.
  cache_pkg::fill_state_t nxt_state;     // Next fill state.
  cache_pkg::word_count_t word_count;    // Words already written for this line.
  logic                   miss;          // A real request missed in the lookup stage.
  logic                   clr_count;     // Restart the counter and address at the line base.
  logic                   incr_cnt;      // One word accepted from memory.
  logic                   chunks_filled; // All words of the line are in.

  assign miss          = lookup_valid & lookup_miss; // Only a real request starts a fill.
  assign chunks_filled = (word_count == cache_pkg::word_count_t'(cache_pkg::WORDS_PER_LINE));

  // The LRU bit names way 0 as victim when set, so way 1 is refilled otherwise.
  assign fill_way = ~victim_is_way0; // Refill the least recently used way.

  // After a hit in way 1 or a refill of way 1, way 0 becomes the next victim.
  assign lru_set_first = lookup_miss ? ~victim_is_way0 : hit_way;

  assign fill_word = cache_pkg::word_sel_t'(word_count[2:0]); // Low count bits pick the slot.
  assign fill_data = mem_data;                                // Memory word goes straight in.

  ////////////////////////////////////////
  // State, word count and address      //
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cache_pkg::FILL_IDLE; // No fill after reset.
    end else begin
      state <= nxt_state;            // Advance the state machine.
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_count <= '0;                                   // Counter starts empty.
    end else if (clr_count) begin
      word_count <= '0;                                   // New miss restarts the count.
    end else if (incr_cnt) begin
      word_count <= word_count + cache_pkg::word_count_t'(1); // One more word written.
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_addr <= '0;                                   // Address register starts at zero.
    end else if (clr_count) begin
      mem_addr <= {lookup_addr[15:4], 4'h0};            // Line base of the missing address.
    end else if (incr_cnt) begin
      mem_addr <= mem_addr + cache_pkg::addr_t'(2);     // Next word is two bytes on.
    end
  end

  ////////////////////////////////////////
  // Transition and output logic        //
  ////////////////////////////////////////
  always_comb begin
    nxt_state  = state; // Stay put unless a branch moves on.
    stall      = 1'b0;  // Processor runs by default.
    mem_req    = 1'b0;  // No memory request by default.
    tag_write  = 1'b0;  // No tag update by default.
    data_write = 1'b0;  // No data update by default.
    clr_count  = 1'b0;  // Counter keeps its value by default.
    incr_cnt   = 1'b0;  // Counter holds by default.
    case (state)
      cache_pkg::FILL_IDLE: begin
        stall     = miss;   // A miss stops the processor in the same cycle.
        clr_count = miss;   // Load the line base while waiting for the grant.
        if (miss && mem_grant) begin
          nxt_state = cache_pkg::FILL_WAIT; // Grant seen, start streaming.
        end
      end
      cache_pkg::FILL_WAIT: begin
        stall      = 1'b1;                            // Held through the tag write.
        mem_req    = 1'b1;                            // Memory owns the fill now.
        data_write = mem_data_valid & ~chunks_filled; // Take each word that arrives.
        incr_cnt   = mem_data_valid & ~chunks_filled; // Count and step the address.
        tag_write  = chunks_filled;                   // Single tag write at the end.
        if (chunks_filled) begin
          nxt_state = cache_pkg::FILL_IDLE;           // Line complete.
        end
      end
      default: begin
        nxt_state = cache_pkg::FILL_IDLE; // Recover from an illegal encoding.
      end
    endcase
  end

endmodule

`default_nettype wire

/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

  ////////////////////////////////////////
  // Widths fixed by the 16-bit machine //
  ////////////////////////////////////////
  typedef logic [15:0] addr_t;      // Byte address from the processor.
  typedef logic [15:0] word_t;      // One data word of a cache line.
  typedef logic [5:0]  tag_t;       // Address bits 15:10.
  typedef logic [5:0]  index_t;     // Address bits 9:4, selects one of the sets.
  typedef logic [2:0]  word_sel_t;  // Address bits 3:1, selects a word in the line.
  typedef logic [3:0]  word_count_t; // Fill counter, runs 0 through 8.

  localparam int WORDS_PER_LINE = 8;  // Words in one cache line.
  localparam int NUM_SETS       = 64; // Sets in each way.

  ////////////////////////////////////////
  // Fill state machine encoding        //
  ////////////////////////////////////////
  // IDLE looks for a miss and waits for the memory grant.
  // WAIT collects the eight words of the line and then writes the tag.
  typedef enum logic {
    FILL_IDLE = 1'b0, // No fill in progress.
    FILL_WAIT = 1'b1  // Line fill streaming from memory.
  } fill_state_t;

endpackage

`default_nettype wire

/* cache_tag_array.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tag_array (
  input  logic             clk,            // System clock.
  input  logic             rst_n,          // Asynchronous reset, active low.
  input  logic             cpu_rd,         // Processor read request.
  input  logic             stall,          // Fill in progress, hold the stage.
  input  logic             tag_write,      // End of fill, write tag and valid.
  input  logic             fill_way,       // Way being refilled.
  input  logic             lru_set_first,  // New LRU bit for the lookup set.
  input  cache_pkg::addr_t cpu_addr,       // Processor byte address.
  output logic             lookup_valid,   // Stage holds a real request.
  output logic             lookup_miss,    // Neither way matches.
  output logic             hit_way,        // Matching way, 1 means way 1.
  output logic             victim_is_way0, // LRU bit of the lookup set.
  output logic             rd_valid,       // Read data is valid this cycle.
  output cache_pkg::addr_t lookup_addr     // Address held in the stage.
);

  cache_pkg::tag_t           tag_way0 [cache_pkg::NUM_SETS]; // Tags of way 0.
  cache_pkg::tag_t           tag_way1 [cache_pkg::NUM_SETS]; // Tags of way 1.
  logic [cache_pkg::NUM_SETS-1:0] valid_way0; // Valid bits of way 0.
  logic [cache_pkg::NUM_SETS-1:0] valid_way1; // Valid bits of way 1.
  logic [cache_pkg::NUM_SETS-1:0] lru;        // Set means way 0 is the victim.
  cache_pkg::index_t         lookup_idx;      // Set of the staged address.
  cache_pkg::tag_t           lookup_tag;      // Tag of the staged address.
  logic                      match0;          // Way 0 holds the staged line.
  logic                      match1;          // Way 1 holds the staged line.

  ////////////////////////////////////////
  // Lookup stage register              //
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lookup_valid <= 1'b0;   // Empty stage after reset.
    end else if (!stall) begin
      lookup_valid <= cpu_rd; // Record whether this cycle carried a request.
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      lookup_addr <= cpu_addr; // Address is held while a fill runs.
    end
  end

  ////////////////////////////////////////
  // Compare                            //
  ////////////////////////////////////////
  assign lookup_idx = lookup_addr[9:4];   // Set index field.
  assign lookup_tag = lookup_addr[15:10]; // Tag field.
  assign match0 = valid_way0[lookup_idx] && (tag_way0[lookup_idx] == lookup_tag);
  assign match1 = valid_way1[lookup_idx] && (tag_way1[lookup_idx] == lookup_tag);

  assign lookup_miss    = ~(match0 | match1);                   // Line absent in both ways.
  assign hit_way        = match1;                               // Way 1 wins the select.
  assign victim_is_way0 = lru[lookup_idx];                      // Current victim choice.
  assign rd_valid       = lookup_valid & ~lookup_miss & ~stall; // Served hit.

  ////////////////////////////////////////
  // Tag, valid and LRU update          //
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_way0 <= '0; // Cache starts empty.
      valid_way1 <= '0;
      lru        <= '0; // Way 1 is the first victim.
      for (int i = 0; i < cache_pkg::NUM_SETS; i++) begin
        tag_way0[i] <= '0; // Known tag contents.
        tag_way1[i] <= '0;
      end
    end else begin
      if (rd_valid || tag_write) begin
        lru[lookup_idx] <= lru_set_first; // Track the most recent use.
      end
      if (tag_write && !fill_way) begin
        tag_way0[lookup_idx]   <= lookup_tag; // New line lands in way 0.
        valid_way0[lookup_idx] <= 1'b1;
      end
      if (tag_write && fill_way) begin
        tag_way1[lookup_idx]   <= lookup_tag; // New line lands in way 1.
        valid_way1[lookup_idx] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top (
  input  logic             clk,            // System clock.
  input  logic             rst_n,          // Asynchronous reset, active low.
  input  logic             cpu_rd,         // Processor read request.
  input  cache_pkg::addr_t cpu_addr,       // Processor byte address.
  output logic             stall,          // Processor must hold its request.
  output logic             rd_valid,       // Read data valid strobe.
  output cache_pkg::word_t rd_data,        // Read data word.
  output logic             mem_req,        // Memory request level.
  output cache_pkg::addr_t mem_addr,       // Address of the word expected next.
  input  logic             mem_grant,      // Memory grant level.
  input  cache_pkg::word_t mem_data,       // Word from memory.
  input  logic             mem_data_valid  // Memory word strobe.
);

  logic                 lookup_valid;   // Stage holds a real request.
  logic                 lookup_miss;    // Lookup found no match.
  logic                 hit_way;        // Matching way.
  logic                 victim_is_way0; // LRU bit of the lookup set.
  logic                 tag_write;      // End of fill strobe.
  logic                 data_write;     // Fill word strobe.
  logic                 fill_way;       // Way being refilled.
  logic                 lru_set_first;  // New LRU bit.
  cache_pkg::addr_t     lookup_addr;    // Staged address.
  cache_pkg::word_sel_t fill_word;      // Fill word slot.
  cache_pkg::word_t     fill_data;      // Fill word data.

  ////////////////////////////////////////
  // Miss handling                      //
  ////////////////////////////////////////
  cache_fill_ctrl u_fill_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .lookup_valid   (lookup_valid),
    .lookup_miss    (lookup_miss),
    .hit_way        (hit_way),
    .victim_is_way0 (victim_is_way0),
    .mem_grant      (mem_grant),
    .mem_data_valid (mem_data_valid),
    .lookup_addr    (lookup_addr),
    .mem_data       (mem_data),
    .stall          (stall),
    .mem_req        (mem_req),
    .tag_write      (tag_write),
    .data_write     (data_write),
    .fill_way       (fill_way),
    .lru_set_first  (lru_set_first),
    .mem_addr       (mem_addr),
    .fill_word      (fill_word),
    .fill_data      (fill_data)
  );

  ////////////////////////////////////////
  // Tag store and lookup stage         //
  ////////////////////////////////////////
  cache_tag_array u_tag_array (
    .clk            (clk),
    .rst_n          (rst_n),
    .cpu_rd         (cpu_rd),
    .stall          (stall),
    .tag_write      (tag_write),
    .fill_way       (fill_way),
    .lru_set_first  (lru_set_first),
    .cpu_addr       (cpu_addr),
    .lookup_valid   (lookup_valid),
    .lookup_miss    (lookup_miss),
    .hit_way        (hit_way),
    .victim_is_way0 (victim_is_way0),
    .rd_valid       (rd_valid),
    .lookup_addr    (lookup_addr)
  );

  // Line storage, read by the staged address.
  cache_data_array u_data_array (
    .clk         (clk),
    .data_write  (data_write),
    .fill_way    (fill_way),
    .hit_way     (hit_way),
    .fill_word   (fill_word),
    .fill_data   (fill_data),
    .lookup_addr (lookup_addr),
    .rd_data     (rd_data)
  );

endmodule

`default_nettype wire

/* src.f */
cache_pkg.sv
cache_fill_ctrl.sv
cache_tag_array.sv
cache_data_array.sv
cache_top.sv
tb_cache_top.sv

/* tb_cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cache_top;

  localparam int CLK_PERIOD   = 8;   // Clock period in ns.
  localparam int NUM_RANDOM   = 400; // Random requests after the directed ones.
  localparam int NUM_DIRECTED = 6;   // Directed eviction sequence.
  localparam int WORST_CYCLES = 100; // Generous bound on one request with a slow fill.

  logic                 clk;
  logic                 rst_n;
  logic                 cpu_rd;
  cache_pkg::addr_t     cpu_addr;
  logic                 stall;
  logic                 rd_valid;
  cache_pkg::word_t     rd_data;
  logic                 mem_req;
  cache_pkg::addr_t     mem_addr;
  logic                 mem_grant;
  cache_pkg::word_t     mem_data;
  logic                 mem_data_valid;

  cache_pkg::word_t mem_model [32768]; // Backing memory, one entry per word address.
  cache_pkg::tag_t  ref_tag   [2][cache_pkg::NUM_SETS]; // Model tags per way and set.
  logic             ref_valid [2][cache_pkg::NUM_SETS]; // Model valid bits.
  logic             ref_lru   [cache_pkg::NUM_SETS];    // Set means way 0 is the victim.
  cache_pkg::addr_t cur_addr;   // Request in flight, used for the fill address check.
  int               words_seen; // Fill words handed to the DUT for this request.
  int               grant_hold; // Remaining cycles of a forced low grant.
  logic             req_d;      // mem_req one cycle earlier.
  logic             grant_d;    // mem_grant one cycle earlier.

  cache_top dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .cpu_rd         (cpu_rd),
    .cpu_addr       (cpu_addr),
    .stall          (stall),
    .rd_valid       (rd_valid),
    .rd_data        (rd_data),
    .mem_req        (mem_req),
    .mem_addr       (mem_addr),
    .mem_grant      (mem_grant),
    .mem_data       (mem_data),
    .mem_data_valid (mem_data_valid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk; // Free running clock.

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, want);
      $display("Errors found");
      $fatal(1, "Stopping at the first mismatch.");
    end
  endtask

  function automatic cache_pkg::addr_t make_addr(input int tag, input int set, input int word);
    return {6'(tag), 6'(set), 3'(word), 1'b0}; // Tag, index, word offset, byte bit.
  endfunction

  ////////////////////////////////////////
  // Memory grant and word stream
  ////////////////////////////////////////
  always @(posedge clk) begin
    #1;
    if (grant_hold > 0) begin
      mem_grant  = 1'b0;                   // Keep the grant away for a while.
      grant_hold = grant_hold - 1;
    end else if ($urandom_range(7) == 0) begin
      mem_grant  = 1'b0;
      grant_hold = $urandom_range(6, 2);   // Start a run of low grant cycles.
    end else begin
      mem_grant = 1'b1;
    end
    mem_data_valid = mem_req && ($urandom_range(3) != 0); // Random idle gaps.
    mem_data       = mem_req ? mem_model[mem_addr[15:1]] : '0;
  end

  // The fill monitor samples mid cycle when everything is settled.
  always @(negedge clk) begin
    if (rst_n) begin
      if (mem_req && !req_d)
        check_value("mem_req rose without a grant", grant_d, 1'b1);
      if (mem_req && mem_data_valid && words_seen < cache_pkg::WORDS_PER_LINE) begin
        check_value("fill address order", mem_addr,
                    {cur_addr[15:4], 4'h0} + 16'(2 * words_seen));
        words_seen = words_seen + 1; // The DUT takes this word at the next edge.
      end
    end
    req_d   = mem_req;
    grant_d = mem_grant;
  end

  // Each read is followed from request to response against the reference model.
  task automatic read_and_check(input cache_pkg::addr_t addr, input int want_hit);
    int   set_i;
    logic m0;
    logic m1;
    logic exp_hit;
    int   victim;
    set_i   = addr[9:4];
    m0      = ref_valid[0][set_i] && (ref_tag[0][set_i] == addr[15:10]);
    m1      = ref_valid[1][set_i] && (ref_tag[1][set_i] == addr[15:10]);
    exp_hit = m0 | m1;
    if (want_hit >= 0)
      check_value("model hit prediction", exp_hit, want_hit[0]);
    cur_addr   = addr;
    words_seen = 0;
    cpu_rd     = 1'b1;
    cpu_addr   = addr;
    @(posedge clk);  // Stall is low here, so the request is accepted.
    #1 cpu_rd = 1'b0;
    @(negedge clk);  // Lookup cycle.
    check_value("stall in lookup cycle", stall, !exp_hit);
    check_value("rd_valid in lookup cycle", rd_valid, exp_hit);
    while (!rd_valid) begin
      check_value("stall held during fill", stall, 1'b1);
      @(negedge clk);
    end
    check_value("stall when data is served", stall, 1'b0);
    check_value("read data", rd_data, mem_model[addr[15:1]]);
    check_value("fill words fetched", words_seen, exp_hit ? 0 : 8);
    if (exp_hit) begin
      ref_lru[set_i] = m1; // The way just used is no longer the victim.
    end else begin
      victim                = ref_lru[set_i] ? 0 : 1;
      ref_tag[victim][set_i]   = addr[15:10];
      ref_valid[victim][set_i] = 1'b1;
      ref_lru[set_i]           = victim[0];
    end
    @(posedge clk);
    #1;
    check_value("rd_valid lasts one cycle", rd_valid, 1'b0);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    void'($urandom(3237)); // Seed the generator once.
    clk            = 1'b0;
    rst_n          = 1'b0;
    cpu_rd         = 1'b0;
    cpu_addr       = '0;
    mem_grant      = 1'b0;
    mem_data       = '0;
    mem_data_valid = 1'b0;
    grant_hold     = 0;
    words_seen     = 0;
    req_d          = 1'b0;
    grant_d        = 1'b0;
    cur_addr       = '0;
    for (int i = 0; i < 32768; i++)
      mem_model[i] = 16'($urandom());
    for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
      ref_valid[0][s] = 1'b0; // Model starts empty like the DUT.
      ref_valid[1][s] = 1'b0;
      ref_lru[s]      = 1'b0;
    end
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    check_value("stall after reset", stall, 1'b0);
    check_value("mem_req after reset", mem_req, 1'b0);
    check_value("rd_valid after reset", rd_valid, 1'b0);
    @(posedge clk);
    #1;
    // Three tags in set 5. B becomes the victim and is evicted by C.
    read_and_check(make_addr(1, 5, 0), 0);
    read_and_check(make_addr(2, 5, 3), 0);
    read_and_check(make_addr(1, 5, 6), 1);
    read_and_check(make_addr(3, 5, 7), 0);
    read_and_check(make_addr(1, 5, 2), 1);
    read_and_check(make_addr(2, 5, 1), 0);
    // Four tags over four sets, so hits and evictions both keep happening.
    for (int n = 0; n < NUM_RANDOM; n++)
      read_and_check(make_addr(3 + 14 * $urandom_range(3), 21 * $urandom_range(3),
                               $urandom_range(7)), -1);
    $display("No errors");
    $finish;
  end

  initial begin
    #((NUM_RANDOM + NUM_DIRECTED) * WORST_CYCLES * CLK_PERIOD);
    $display("Errors found");
    $fatal(1, "Timeout, the read requests did not finish in time.");
  end

endmodule

`default_nettype wire
